// File: Makefile
# Verilator build and run for the axis_out stream peripheral

SIM    ?= verilator
TOP    ?= tb_axis_out
FLIST  ?= project.f
MDIR   ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(MDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FLIST)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf $(MDIR)

// File: project.f
src/axis_out_csr_pkg.sv
src/axis_out_stream_pkg.sv
src/axis_out_csr.sv
src/axis_out_fifo.sv
src/axis_out_framer.sv
src/axis_out_top.sv
tests/tb_axis_out.sv

// File: src/axis_out_csr.sv
// ************************************************************
// axis_out register file: control registers, status reads,
// FIFO write source selection and the level interrupt
// ************************************************************

`timescale 1ns/1ps

module axis_out_csr #(
   parameter int FIFO_ADDR_W = 4
) (
   input  logic                                    clk_i,
   input  logic                                    rst_n_i,
   // register port
   input  logic                                    csr_wen_i,
   input  logic                                    csr_ren_i,
   input  logic [axis_out_csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
   input  logic [axis_out_stream_pkg::DATA_W-1:0]  csr_wdata_i,
   input  logic [axis_out_stream_pkg::LANES-1:0]   csr_wstrb_i,
   output logic [axis_out_stream_pkg::DATA_W-1:0]  csr_rdata_o,
   output logic                                    csr_ready_o,
   // DMA stream
   input  logic                                    sys_tvalid_i,
   input  logic [axis_out_stream_pkg::DATA_W-1:0]  sys_tdata_i,
   output logic                                    sys_tready_o,
   output logic                                    interrupt_o,
   // control towards fifo and framer
   output logic                                    soft_rst_o,
   output logic                                    enable_o,
   output logic [axis_out_csr_pkg::NWORDS_W-1:0]   nwords_o,
   // fifo write side
   input  logic                                    fifo_full_i,
   input  logic                                    fifo_empty_i,
   input  logic [FIFO_ADDR_W:0]                    fifo_level_i,
   output logic                                    fifo_wen_o,
   output axis_out_stream_pkg::stream_word_t       fifo_wdata_o
);

   import axis_out_stream_pkg::*;
   import axis_out_csr_pkg::*;

   logic                 mode_q;
   logic [FIFO_ADDR_W:0] threshold_q;
   logic                 host_wen;
   logic [LEVEL_W-1:0]   level_field;

   // control registers
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         soft_rst_o  <= 1'b0;
         enable_o    <= 1'b0;
         mode_q      <= 1'b0;
         nwords_o    <= '0;
         threshold_q <= '0;
      end else if (csr_wen_i) begin
         case (csr_addr_i)
            ADDR_SOFT_RESET: soft_rst_o  <= csr_wdata_i[0];
            ADDR_ENABLE:     enable_o    <= csr_wdata_i[0];
            ADDR_MODE:       mode_q      <= csr_wdata_i[0];
            ADDR_NWORDS:     nwords_o    <= csr_wdata_i[NWORDS_W-1:0];
            ADDR_THRESHOLD:  threshold_q <= csr_wdata_i[FIFO_ADDR_W:0];
            default: ;
         endcase
      end
   end

   // level zero extended into its register field
   assign level_field = LEVEL_W'(fifo_level_i);

   // read data one cycle after the strobe
   always_ff @(posedge clk_i) begin
      if (csr_ren_i) begin
         csr_rdata_o <= '0;
         case (csr_addr_i)
            ADDR_STATUS: begin
               csr_rdata_o[STATUS_FULL_BIT]  <= fifo_full_i;
               csr_rdata_o[STATUS_EMPTY_BIT] <= fifo_empty_i;
            end
            ADDR_LEVEL: csr_rdata_o[LEVEL_W-1:0] <= level_field;
            default: ;
         endcase
      end
   end

   // host data path, taken only with room and a byte strobe
   assign csr_ready_o = ~fifo_full_i;
   assign host_wen    = csr_wen_i & (csr_addr_i == ADDR_DATA) & csr_ready_o & (|csr_wstrb_i);

   // dma side only accepts while enabled in DMA mode
   assign sys_tready_o = ~fifo_full_i & enable_o & (mode_q == MODE_DMA);

   // write source picked by mode
   always_comb begin
      if (mode_q == MODE_DMA) begin
         fifo_wen_o        = sys_tvalid_i & sys_tready_o;
         fifo_wdata_o.word = sys_tdata_i;
      end else begin
         fifo_wen_o        = host_wen & enable_o;
         fifo_wdata_o.word = csr_wdata_i;
      end
   end

   // level interrupt, fires at or below the threshold
   assign interrupt_o = (fifo_level_i <= threshold_q);

   // a taken write shows up as a non-empty fifo one cycle later
   a_write_not_empty: assert property (
      @(posedge clk_i) disable iff (!rst_n_i || soft_rst_o)
      fifo_wen_o |=> !fifo_empty_i
   ) else $error("csr: fifo still empty after a write");

endmodule

// File: src/axis_out_csr_pkg.sv
// ************************************************************
// axis_out register map: addresses, mode values and field
// widths of the host register port
// ************************************************************

package axis_out_csr_pkg;

   // register address width
   parameter int CSR_ADDR_W = 4;

   // write registers
   parameter logic [CSR_ADDR_W-1:0] ADDR_SOFT_RESET = 4'd0;
   parameter logic [CSR_ADDR_W-1:0] ADDR_ENABLE     = 4'd1;
   parameter logic [CSR_ADDR_W-1:0] ADDR_MODE       = 4'd2;
   parameter logic [CSR_ADDR_W-1:0] ADDR_DATA       = 4'd3;
   parameter logic [CSR_ADDR_W-1:0] ADDR_NWORDS     = 4'd4;
   parameter logic [CSR_ADDR_W-1:0] ADDR_THRESHOLD  = 4'd5;

   // read registers
   parameter logic [CSR_ADDR_W-1:0] ADDR_STATUS = 4'd6;
   parameter logic [CSR_ADDR_W-1:0] ADDR_LEVEL  = 4'd7;

   // status bit positions
   parameter int STATUS_FULL_BIT  = 0;
   parameter int STATUS_EMPTY_BIT = 1;

   // mode 0 is host writes, mode 1 is the DMA stream
   parameter logic MODE_DMA = 1'b1;

   // field widths
   parameter int NWORDS_W = 32;
   parameter int LEVEL_W  = 16;

endpackage

// File: src/axis_out_fifo.sv
// ************************************************************
// axis_out FIFO: 32-bit words in, bytes out lane 0 first,
// with full, empty and word level
// ************************************************************

`timescale 1ns/1ps

module axis_out_fifo #(
   parameter int FIFO_ADDR_W = 4
) (
   input  logic                                    clk_i,
   input  logic                                    rst_n_i,
   input  logic                                    soft_rst_i,
   // write side
   input  logic                                    wen_i,
   input  axis_out_stream_pkg::stream_word_t       wdata_i,
   // read side
   input  logic                                    ren_i,
   output logic [axis_out_stream_pkg::TDATA_W-1:0] rdata_o,
   // status
   output logic                                    empty_o,
   output logic                                    full_o,
   output logic [FIFO_ADDR_W:0]                    level_o
);

   import axis_out_stream_pkg::*;

   localparam int DEPTH  = 1 << FIFO_ADDR_W;
   localparam int LANE_W = $clog2(LANES);

   stream_word_t         mem [DEPTH];
   stream_word_t         head;
   // pointers carry one extra wrap bit
   logic [FIFO_ADDR_W:0] wr_ptr_q;
   logic [FIFO_ADDR_W:0] rd_ptr_q;
   logic [LANE_W-1:0]    lane_q;
   logic                 last_lane;

   assign head      = mem[rd_ptr_q[FIFO_ADDR_W-1:0]];
   assign last_lane = (lane_q == LANE_W'(LANES - 1));

   // storage
   always_ff @(posedge clk_i) begin
      if (wen_i) begin
         mem[wr_ptr_q[FIFO_ADDR_W-1:0]] <= wdata_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i || soft_rst_i) begin
         wr_ptr_q <= '0;
      end else if (wen_i) begin
         wr_ptr_q <= wr_ptr_q + 1'b1;
      end
   end

   // lane walk, head word retires after its last byte
   always_ff @(posedge clk_i) begin
      if (!rst_n_i || soft_rst_i) begin
         rd_ptr_q <= '0;
         lane_q   <= '0;
      end else if (ren_i) begin
         lane_q <= lane_q + 1'b1;
         if (last_lane) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   // byte out one cycle after the read
   always_ff @(posedge clk_i) begin
      if (ren_i) begin
         rdata_o <= head.lane[lane_q];
      end
   end

   // partly read head word still counts
   assign level_o = wr_ptr_q - rd_ptr_q;
   assign empty_o = (level_o == '0);
   assign full_o  = (level_o == (FIFO_ADDR_W + 1)'(DEPTH));

   // framer and csr must honour the flags
   a_no_read_empty: assert property (
      @(posedge clk_i) disable iff (!rst_n_i || soft_rst_i)
      ren_i |-> !empty_o
   ) else $error("fifo: read while empty");

   a_no_write_full: assert property (
      @(posedge clk_i) disable iff (!rst_n_i || soft_rst_i)
      wen_i |-> !full_o
   ) else $error("fifo: write while full");

endmodule

// File: src/axis_out_framer.sv
// ************************************************************
// axis_out framer: reads bytes from the FIFO, counts them,
// marks tlast and drains padding past nwords
// ************************************************************

`timescale 1ns/1ps

module axis_out_framer (
   input  logic                                    clk_i,
   input  logic                                    rst_n_i,
   input  logic                                    soft_rst_i,
   input  logic                                    enable_i,
   input  logic [axis_out_csr_pkg::NWORDS_W-1:0]   nwords_i,
   // fifo read side
   input  logic                                    fifo_empty_i,
   input  logic [axis_out_stream_pkg::TDATA_W-1:0] fifo_rdata_i,
   output logic                                    fifo_ren_o,
   // AXI-Stream master
   output logic                                    axis_tvalid_o,
   output logic [axis_out_stream_pkg::TDATA_W-1:0] axis_tdata_o,
   output logic                                    axis_tlast_o,
   input  logic                                    axis_tready_i
);

   import axis_out_csr_pkg::*;

   // idle or holding one byte
   logic                hold_q;
   logic                hold_nxt;
   logic [NWORDS_W-1:0] byte_cnt_q;
   logic                in_frame;

   // count already includes the held byte
   assign in_frame = (byte_cnt_q <= nwords_i);

   always_comb begin
      hold_nxt      = hold_q;
      fifo_ren_o    = 1'b0;
      axis_tvalid_o = 1'b0;
      if (enable_i) begin
         if (!hold_q) begin
            if (!fifo_empty_i) begin
               fifo_ren_o = 1'b1;
               hold_nxt   = 1'b1;
            end
         end else if (in_frame) begin
            axis_tvalid_o = 1'b1;
            if (axis_tready_i) begin
               // next byte straight away, or back to idle
               fifo_ren_o = ~fifo_empty_i;
               hold_nxt   = ~fifo_empty_i;
            end
         end else begin
            // padding byte, dropped without tvalid
            fifo_ren_o = ~fifo_empty_i;
            hold_nxt   = ~fifo_empty_i;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i || soft_rst_i) begin
         hold_q     <= 1'b0;
         byte_cnt_q <= '0;
      end else begin
         hold_q <= hold_nxt;
         if (fifo_ren_o) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
         end
      end
   end

   // fifo output register holds the byte while stalled
   assign axis_tdata_o = fifo_rdata_i;
   assign axis_tlast_o = axis_tvalid_o & (byte_cnt_q == nwords_i);

   // one tlast per frame, the bytes after it are padding
   a_no_byte_after_last: assert property (
      @(posedge clk_i) disable iff (!rst_n_i || soft_rst_i)
      (axis_tlast_o && axis_tready_i) |=> (!axis_tvalid_o || $changed(nwords_i))
   ) else $error("framer: byte offered after tlast");

   a_data_stable: assert property (
      @(posedge clk_i) disable iff (!rst_n_i || soft_rst_i)
      (axis_tvalid_o && !axis_tready_i) |=> $stable(axis_tdata_o)
   ) else $error("framer: tdata changed under back-pressure");

endmodule

// File: src/axis_out_stream_pkg.sv
// ************************************************************
// axis_out stream widths and the word/lane view of a FIFO word
// ************************************************************

package axis_out_stream_pkg;

   // bus word and stream byte
   parameter int DATA_W  = 32;
   parameter int TDATA_W = 8;

   // bytes per word
   parameter int LANES = DATA_W / TDATA_W;

   // one bus word, seen whole or as byte lanes
   // lane 0 is the least significant byte and leaves first
   typedef union packed {
      logic [DATA_W-1:0]              word;
      logic [LANES-1:0][TDATA_W-1:0] lane;
   } stream_word_t;

endpackage

// File: src/axis_out_top.sv
// ************************************************************
// axis_out top: register file, byte FIFO and stream framer
// ************************************************************

`timescale 1ns/1ps

module axis_out_top #(
   parameter int FIFO_ADDR_W = 4
) (
   input  logic                                    clk_i,
   input  logic                                    rst_n_i,
   // register port
   input  logic                                    csr_wen_i,
   input  logic                                    csr_ren_i,
   input  logic [axis_out_csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
   input  logic [axis_out_stream_pkg::DATA_W-1:0]  csr_wdata_i,
   input  logic [axis_out_stream_pkg::LANES-1:0]   csr_wstrb_i,
   output logic [axis_out_stream_pkg::DATA_W-1:0]  csr_rdata_o,
   output logic                                    csr_ready_o,
   // DMA stream
   input  logic                                    sys_tvalid_i,
   input  logic [axis_out_stream_pkg::DATA_W-1:0]  sys_tdata_i,
   output logic                                    sys_tready_o,
   // AXI-Stream out
   output logic                                    axis_tvalid_o,
   output logic [axis_out_stream_pkg::TDATA_W-1:0] axis_tdata_o,
   output logic                                    axis_tlast_o,
   input  logic                                    axis_tready_i,
   output logic                                    interrupt_o
);

   import axis_out_stream_pkg::*;
   import axis_out_csr_pkg::*;

   logic                 soft_rst;
   logic                 enable;
   logic [NWORDS_W-1:0]  nwords;
   logic                 fifo_wen;
   stream_word_t         fifo_wdata;
   logic                 fifo_full;
   logic                 fifo_empty;
   logic [FIFO_ADDR_W:0] fifo_level;
   logic                 fifo_ren;
   logic [TDATA_W-1:0]   fifo_rdata;

   axis_out_csr #(
      .FIFO_ADDR_W(FIFO_ADDR_W)
   ) csr0 (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .csr_wen_i   (csr_wen_i),
      .csr_ren_i   (csr_ren_i),
      .csr_addr_i  (csr_addr_i),
      .csr_wdata_i (csr_wdata_i),
      .csr_wstrb_i (csr_wstrb_i),
      .csr_rdata_o (csr_rdata_o),
      .csr_ready_o (csr_ready_o),
      .sys_tvalid_i(sys_tvalid_i),
      .sys_tdata_i (sys_tdata_i),
      .sys_tready_o(sys_tready_o),
      .interrupt_o (interrupt_o),
      .soft_rst_o  (soft_rst),
      .enable_o    (enable),
      .nwords_o    (nwords),
      .fifo_full_i (fifo_full),
      .fifo_empty_i(fifo_empty),
      .fifo_level_i(fifo_level),
      .fifo_wen_o  (fifo_wen),
      .fifo_wdata_o(fifo_wdata)
   );

   axis_out_fifo #(
      .FIFO_ADDR_W(FIFO_ADDR_W)
   ) fifo0 (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .soft_rst_i(soft_rst),
      .wen_i     (fifo_wen),
      .wdata_i   (fifo_wdata),
      .ren_i     (fifo_ren),
      .rdata_o   (fifo_rdata),
      .empty_o   (fifo_empty),
      .full_o    (fifo_full),
      .level_o   (fifo_level)
   );

   axis_out_framer framer0 (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .soft_rst_i   (soft_rst),
      .enable_i     (enable),
      .nwords_i     (nwords),
      .fifo_empty_i (fifo_empty),
      .fifo_rdata_i (fifo_rdata),
      .fifo_ren_o   (fifo_ren),
      .axis_tvalid_o(axis_tvalid_o),
      .axis_tdata_o (axis_tdata_o),
      .axis_tlast_o (axis_tlast_o),
      .axis_tready_i(axis_tready_i)
   );

endmodule

// File: tests/tb_axis_out.sv
// ************************************************************
// axis_out testbench: host and DMA frames, back-pressure,
// padding, full and level, soft reset, stream scoreboard
// ************************************************************

`timescale 1ns/1ps

module tb_axis_out;

   import axis_out_csr_pkg::*;

   localparam int READY_LIMIT = 50;
   localparam int DRAIN_LIMIT = 400;
   localparam int POLL_LIMIT  = 20;

   logic        clk_i;
   logic        rst_n_i;
   logic        csr_wen_i;
   logic        csr_ren_i;
   logic [3:0]  csr_addr_i;
   logic [31:0] csr_wdata_i;
   logic [3:0]  csr_wstrb_i;
   logic [31:0] csr_rdata_o;
   logic        csr_ready_o;
   logic        sys_tvalid_i;
   logic [31:0] sys_tdata_i;
   logic        sys_tready_o;
   logic        axis_tvalid_o;
   logic [7:0]  axis_tdata_o;
   logic        axis_tlast_o;
   logic        axis_tready_i;
   logic        interrupt_o;

   // expected bytes with their tlast bit on top
   logic [8:0]  exp_bytes [1024];
   int          exp_wr = 0;
   int          exp_rd = 0;
   int          frame_cnt = 0;
   int          frame_len = 0;
   logic [7:0]  exp_data;
   logic        exp_last;
   logic        exp_avail;
   logic        accept;
   logic [31:0] rng_state = 32'h2f6b_25dd;

   axis_out_top dut0 (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .csr_wen_i    (csr_wen_i),
      .csr_ren_i    (csr_ren_i),
      .csr_addr_i   (csr_addr_i),
      .csr_wdata_i  (csr_wdata_i),
      .csr_wstrb_i  (csr_wstrb_i),
      .csr_rdata_o  (csr_rdata_o),
      .csr_ready_o  (csr_ready_o),
      .sys_tvalid_i (sys_tvalid_i),
      .sys_tdata_i  (sys_tdata_i),
      .sys_tready_o (sys_tready_o),
      .axis_tvalid_o(axis_tvalid_o),
      .axis_tdata_o (axis_tdata_o),
      .axis_tlast_o (axis_tlast_o),
      .axis_tready_i(axis_tready_i),
      .interrupt_o  (interrupt_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   assign exp_data  = exp_bytes[exp_rd[9:0]][7:0];
   assign exp_last  = exp_bytes[exp_rd[9:0]][8];
   assign exp_avail = (exp_rd < exp_wr);
   assign accept    = axis_tvalid_o & axis_tready_i;

   // scoreboard advances on each accepted byte
   always @(posedge clk_i) begin
      if (rst_n_i && accept) begin
         exp_rd <= exp_rd + 1;
      end
   end

   function logic [31:0] rand32();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   task automatic stop_with_failure();
      $display("FAIL: see errors above");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic timeout_fail(input string what);
      $display("timeout while waiting for %s at %0t", what, $time);
      stop_with_failure();
   endtask

   task automatic expect_equal(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
      a_value: assert (act == exp) else begin
         $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
         stop_with_failure();
      end
   endtask

   a_byte_expected: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      accept |-> exp_avail
   ) else begin
      $display("byte accepted at %0t with no byte left in the expected frame", $time);
      stop_with_failure();
   end

   a_tdata: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      accept |-> (axis_tdata_o == exp_data)
   ) else begin
      $display("ERR %0t axis_tdata_o expected %h actual %h", $time,
               $sampled(exp_data), $sampled(axis_tdata_o));
      stop_with_failure();
   end

   a_tlast: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      accept |-> (axis_tlast_o == exp_last)
   ) else begin
      $display("ERR %0t axis_tlast_o expected %b actual %b", $time,
               $sampled(exp_last), $sampled(axis_tlast_o));
      stop_with_failure();
   end

   a_hold: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (axis_tvalid_o && !axis_tready_i) |=> ($stable(axis_tdata_o) && $stable(axis_tlast_o))
   ) else begin
      $display("tdata or tlast changed while tready was low at %0t", $time);
      stop_with_failure();
   end

   task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
      @(negedge clk_i);
      csr_wen_i   = 1'b1;
      csr_addr_i  = addr;
      csr_wdata_i = data;
      csr_wstrb_i = 4'hf;
      @(negedge clk_i);
      csr_wen_i = 1'b0;
   endtask

   task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
      @(negedge clk_i);
      csr_ren_i  = 1'b1;
      csr_addr_i = addr;
      @(negedge clk_i);
      csr_ren_i = 1'b0;
      data      = csr_rdata_o;
   endtask

   // lane 0 first, bytes past nwords never show up
   task automatic record_word(input logic [31:0] w);
      for (int lane = 0; lane < 4; lane++) begin
         frame_cnt = frame_cnt + 1;
         if (frame_cnt <= frame_len) begin
            exp_bytes[exp_wr[9:0]] = {frame_cnt == frame_len, w[8*lane +: 8]};
            exp_wr = exp_wr + 1;
         end
      end
   endtask

   task automatic soft_reset();
      reg_write(ADDR_SOFT_RESET, 32'd1);
      reg_write(ADDR_SOFT_RESET, 32'd0);
      frame_cnt = 0;
   endtask

   task automatic set_frame(input int n);
      reg_write(ADDR_NWORDS, 32'(n));
      frame_len = n;
   endtask

   task automatic host_write(input logic [31:0] w, input bit record);
      int tries;
      tries = 0;
      @(negedge clk_i);
      while (!csr_ready_o && tries < READY_LIMIT) begin
         @(negedge clk_i);
         tries++;
      end
      if (!csr_ready_o) begin
         timeout_fail("csr_ready_o");
      end else begin
         csr_wen_i   = 1'b1;
         csr_addr_i  = ADDR_DATA;
         csr_wdata_i = w;
         csr_wstrb_i = 4'hf;
         if (record) begin
            record_word(w);
         end
         @(negedge clk_i);
         csr_wen_i = 1'b0;
      end
   endtask

   task automatic dma_send(input logic [31:0] w);
      int tries;
      tries = 0;
      @(negedge clk_i);
      sys_tvalid_i = 1'b1;
      sys_tdata_i  = w;
      while (!sys_tready_o && tries < READY_LIMIT) begin
         @(negedge clk_i);
         tries++;
      end
      if (!sys_tready_o) begin
         timeout_fail("sys_tready_o");
      end else begin
         record_word(w);
         @(negedge clk_i);
         sys_tvalid_i = 1'b0;
      end
   endtask

   task automatic wait_drain(input bit random_ready);
      int          cycles;
      logic [31:0] r;
      cycles = 0;
      while (exp_rd != exp_wr && cycles < DRAIN_LIMIT) begin
         @(negedge clk_i);
         r             = rand32();
         axis_tready_i = random_ready ? r[7] : 1'b1;
         cycles++;
      end
      if (exp_rd != exp_wr) begin
         timeout_fail("the expected stream bytes");
      end else begin
         axis_tready_i = 1'b1;
      end
   endtask

   task automatic wait_valid();
      int tries;
      tries = 0;
      @(negedge clk_i);
      while (!axis_tvalid_o && tries < READY_LIMIT) begin
         @(negedge clk_i);
         tries++;
      end
      if (!axis_tvalid_o) begin
         timeout_fail("axis_tvalid_o");
      end
   endtask

   task automatic wait_status_empty();
      logic [31:0] status;
      int          tries;
      tries = 0;
      reg_read(ADDR_STATUS, status);
      while (!status[STATUS_EMPTY_BIT] && tries < POLL_LIMIT) begin
         reg_read(ADDR_STATUS, status);
         tries++;
      end
      if (!status[STATUS_EMPTY_BIT]) begin
         timeout_fail("an empty FIFO status");
      end else begin
         expect_equal("status", 32'h2, status);
      end
   endtask

   task automatic run_host_frame();
      soft_reset();
      set_frame(8);
      reg_write(ADDR_MODE, 32'd0);
      reg_write(ADDR_ENABLE, 32'd1);
      axis_tready_i = 1'b1;
      host_write(32'h4433_2211, 1'b1);
      host_write(32'h8877_6655, 1'b1);
      wait_drain(1'b0);
   endtask

   task automatic run_backpressure();
      soft_reset();
      set_frame(12);
      axis_tready_i = 1'b0;
      repeat (3) host_write(rand32(), 1'b1);
      wait_drain(1'b1);
   endtask

   // two words with nwords of 6, the last two bytes are padding
   task automatic run_padding();
      soft_reset();
      set_frame(6);
      host_write(rand32(), 1'b1);
      host_write(rand32(), 1'b1);
      wait_drain(1'b0);
      wait_status_empty();
   endtask

   task automatic run_dma();
      soft_reset();
      set_frame(8);
      reg_write(ADDR_MODE, 32'd1);
      expect_equal("sys_tready_o", 32'd1, 32'(sys_tready_o));
      // host data must not reach the FIFO in DMA mode
      host_write(32'hdead_beef, 1'b0);
      dma_send(rand32());
      dma_send(rand32());
      wait_drain(1'b1);
      wait_status_empty();
      reg_write(ADDR_MODE, 32'd0);
      expect_equal("sys_tready_o", 32'd0, 32'(sys_tready_o));
   endtask

   task automatic run_full_level();
      logic [31:0] value;
      soft_reset();
      set_frame(64);
      reg_write(ADDR_THRESHOLD, 32'd4);
      // sink stalls so the framer holds one byte and reads no further
      axis_tready_i = 1'b0;
      repeat (16) host_write(rand32(), 1'b1);
      reg_read(ADDR_STATUS, value);
      expect_equal("status", 32'h1, value);
      expect_equal("csr_ready_o", 32'd0, 32'(csr_ready_o));
      reg_write(ADDR_DATA, 32'hbad0_0bad);
      reg_read(ADDR_LEVEL, value);
      expect_equal("level", 32'd16, value);
      expect_equal("interrupt_o", 32'd0, 32'(interrupt_o));
      wait_drain(1'b0);
      wait_status_empty();
      expect_equal("interrupt_o", 32'd1, 32'(interrupt_o));
   endtask

   task automatic run_soft_reset();
      logic [31:0] value;
      soft_reset();
      set_frame(8);
      axis_tready_i = 1'b0;
      // this frame is thrown away by the soft reset
      host_write(32'h0102_0304, 1'b0);
      host_write(32'h0506_0708, 1'b0);
      wait_valid();
      reg_write(ADDR_ENABLE, 32'd0);
      axis_tready_i = 1'b1;
      repeat (4) begin
         @(negedge clk_i);
         expect_equal("axis_tvalid_o", 32'd0, 32'(axis_tvalid_o));
      end
      soft_reset();
      reg_read(ADDR_STATUS, value);
      expect_equal("status", 32'h2, value);
      set_frame(4);
      reg_write(ADDR_ENABLE, 32'd1);
      host_write(32'hc3b2_a190, 1'b1);
      wait_drain(1'b1);
      wait_status_empty();
   endtask

   initial begin
      rst_n_i       = 1'b0;
      csr_wen_i     = 1'b0;
      csr_ren_i     = 1'b0;
      csr_addr_i    = '0;
      csr_wdata_i   = '0;
      csr_wstrb_i   = '0;
      sys_tvalid_i  = 1'b0;
      sys_tdata_i   = '0;
      axis_tready_i = 1'b0;
      repeat (3) @(negedge clk_i);
      rst_n_i = 1'b1;
      expect_equal("axis_tvalid_o", 32'd0, 32'(axis_tvalid_o));
      expect_equal("sys_tready_o", 32'd0, 32'(sys_tready_o));
      run_host_frame();
      run_backpressure();
      run_padding();
      run_dma();
      run_full_level();
      run_soft_reset();
      $display("PASS: all tests");
      $finish;
   end

endmodule
